/* src/cache_pkg.sv */
package cache_pkg;

  ////////////////////////////////////////////////////////////
  // Cache geometry
  ////////////////////////////////////////////////////////////

  localparam int word_bits     = 32;
  localparam int line_bits     = 128;  // Four words to a line.
  localparam int num_ways      = 2;
  localparam int lines_per_way = 16;
  localparam int offset_bits   = 4;
  localparam int index_bits    = 4;
  localparam int tag_bits      = word_bits - index_bits - offset_bits;

  localparam int words_per_line = line_bits / word_bits;
  localparam int word_sel_bits  = $clog2(words_per_line);

  // The core may have this many requests in flight.
  localparam int core_credits = 1;

  typedef logic [word_bits-1:0]  word_t;
  typedef logic [line_bits-1:0]  line_t;
  typedef logic [tag_bits-1:0]   tag_t;
  typedef logic [index_bits-1:0] index_t;
  typedef logic [num_ways-1:0]   way_vec_t;

  ////////////////////////////////////////////////////////////
  // Port structs
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic  write;
    word_t addr;
    word_t wdata;
  } core_req_t;

  // Writes return the word that was stored.
  typedef struct packed {
    word_t rdata;
  } core_rsp_t;

  typedef struct packed {
    logic  write;
    word_t addr;   // Line aligned.
    line_t wdata;
  } mem_req_t;

  ////////////////////////////////////////////////////////////
  // Control and datapath handshake
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic capture;          // Latch a new core request.
    logic write_hit;        // Store the merged line into the hitting way.
    logic allocate;         // Load the refill line into the victim way.
    logic victim_addr_sel;  // Address memory with the victim's tag.
    logic nmru_update;      // Record the hitting way as last used.
  } ctl_cmd_t;

  typedef struct packed {
    logic hit;           // Some valid way matches the request tag.
    logic victim_dirty;  // The NMRU victim is valid and dirty.
    logic req_write;     // The latched request is a write.
  } dp_status_t;

  typedef enum logic [2:0] {
    idle,
    lookup,
    writeback,
    refill,
    respond
  } ctl_state_t;

endpackage

/* src/line_array.sv */
`timescale 1ns/1ps

module line_array #(
  parameter int width          = 1,
  parameter int depth          = 16,
  parameter bit clear_on_reset = 1'b0
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               load,
  input  cache_pkg::index_t  index,
  input  logic [width-1:0]   data_in,
  output logic [width-1:0]   data_out
);

  logic [width-1:0] mem [depth];

  if (clear_on_reset) begin : g_flags
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        for (int i = 0; i < depth; i++) begin
          mem[i] <= '0;
        end
      end else if (load) begin
        mem[index] <= data_in;
      end
    end
  end else begin : g_store
    always_ff @(posedge clk) begin
      if (load) mem[index] <= data_in;
    end
  end

  assign data_out = mem[index];  // Read port sees the write only after the edge.

endmodule

/* src/nmru_policy.sv */
`timescale 1ns/1ps

module nmru_policy (
  input  logic                clk,
  input  logic                rst_n,
  input  cache_pkg::index_t   index,
  input  logic                update,
  input  cache_pkg::way_vec_t hit_vec,
  output cache_pkg::way_vec_t victim_vec
);
  import cache_pkg::*;

  localparam int way_num_bits = (num_ways > 1) ? $clog2(num_ways) : 1;

  logic [way_num_bits-1:0] last_used [lines_per_way];
  logic [way_num_bits-1:0] hit_way;
  logic                    found;

  // Encode the one-hot hit vector into a way number.
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (hit_vec[w]) hit_way = way_num_bits'(w);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < lines_per_way; i++) begin
        last_used[i] <= '0;
      end
    end else if (update) begin
      last_used[index] <= hit_way;
    end
  end

  // The lowest-numbered way that was not last used is evicted.
  always_comb begin
    victim_vec = '0;
    found      = 1'b0;
    for (int w = 0; w < num_ways; w++) begin
      if (!found && (way_num_bits'(w) != last_used[index])) begin
        victim_vec[w] = 1'b1;
        found         = 1'b1;
      end
    end
  end

endmodule

/* src/cache_datapath.sv */
`timescale 1ns/1ps

module cache_datapath (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cache_pkg::core_req_t  core_req,
  input  cache_pkg::ctl_cmd_t   cmd,
  input  cache_pkg::line_t      mem_rdata,
  input  cache_pkg::way_vec_t   victim_vec,
  output cache_pkg::dp_status_t status,
  output cache_pkg::index_t     index,
  output cache_pkg::way_vec_t   hit_vec,
  output cache_pkg::word_t      rsp_data,
  output cache_pkg::word_t      mem_addr,
  output cache_pkg::line_t      mem_wdata
);
  import cache_pkg::*;

  core_req_t                req_q;
  tag_t                     req_tag;
  logic [word_sel_bits-1:0] word_sel;

  logic  valid_rd [num_ways];
  logic  dirty_rd [num_ways];
  tag_t  tag_rd   [num_ways];
  line_t data_rd  [num_ways];

  way_vec_t way_load;
  logic     dirty_in;
  line_t    line_in;
  line_t    hit_line;
  line_t    merged_line;
  line_t    victim_line;
  tag_t     victim_tag;
  logic     victim_valid;
  logic     victim_dirty;

  always_ff @(posedge clk) begin
    if (cmd.capture) req_q <= core_req;
  end

  assign req_tag  = req_q.addr[word_bits-1 -: tag_bits];
  assign index    = req_q.addr[offset_bits +: index_bits];
  assign word_sel = req_q.addr[offset_bits-1 -: word_sel_bits];

  ////////////////////////////////////////////////////////////
  // Per-way arrays
  ////////////////////////////////////////////////////////////

  for (genvar w = 0; w < num_ways; w++) begin : g_way
    line_array #(.width(1), .depth(lines_per_way), .clear_on_reset(1'b1)) u_valid (
      .clk, .rst_n, .load(way_load[w]), .index, .data_in(1'b1), .data_out(valid_rd[w])
    );
    line_array #(.width(tag_bits), .depth(lines_per_way), .clear_on_reset(1'b0)) u_tag (
      .clk, .rst_n, .load(way_load[w]), .index, .data_in(req_tag), .data_out(tag_rd[w])
    );
    line_array #(.width(1), .depth(lines_per_way), .clear_on_reset(1'b1)) u_dirty (
      .clk, .rst_n, .load(way_load[w]), .index, .data_in(dirty_in), .data_out(dirty_rd[w])
    );
    line_array #(.width(line_bits), .depth(lines_per_way), .clear_on_reset(1'b0)) u_data (
      .clk, .rst_n, .load(way_load[w]), .index, .data_in(line_in), .data_out(data_rd[w])
    );
  end

  ////////////////////////////////////////////////////////////
  // Lookup and victim selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    hit_vec      = '0;
    hit_line     = '0;
    victim_line  = '0;
    victim_tag   = '0;
    victim_valid = 1'b0;
    victim_dirty = 1'b0;
    for (int w = 0; w < num_ways; w++) begin
      if (valid_rd[w] && (tag_rd[w] == req_tag)) begin
        hit_vec[w] = 1'b1;
        hit_line   = data_rd[w];
      end
      if (victim_vec[w]) begin
        victim_line  = data_rd[w];
        victim_tag   = tag_rd[w];
        victim_valid = valid_rd[w];
        victim_dirty = dirty_rd[w];
      end
    end
  end

  always_comb begin
    merged_line = hit_line;
    merged_line[word_sel*word_bits +: word_bits] = req_q.wdata;
  end

  // A refill always lands clean, a write hit always leaves the line dirty.
  assign dirty_in = cmd.write_hit;
  assign line_in  = cmd.allocate ? mem_rdata : merged_line;

  for (genvar w = 0; w < num_ways; w++) begin : g_load
    assign way_load[w] = (cmd.write_hit & hit_vec[w]) | (cmd.allocate & victim_vec[w]);
  end

  assign status.hit          = |hit_vec;
  assign status.victim_dirty = victim_valid & victim_dirty;
  assign status.req_write    = req_q.write;

  assign rsp_data  = hit_line[word_sel*word_bits +: word_bits];  // Holds the new word after a write.
  assign mem_addr  = {(cmd.victim_addr_sel ? victim_tag : req_tag), index, {offset_bits{1'b0}}};
  assign mem_wdata = victim_line;

endmodule

/* src/cache_control.sv */
`timescale 1ns/1ps

module cache_control (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  core_req_valid,
  input  logic                  write,
  input  cache_pkg::dp_status_t status,
  input  logic                  mem_done,
  output cache_pkg::ctl_cmd_t   cmd,
  output logic                  mem_req_valid,
  output logic                  mem_write,
  output logic                  core_rsp_valid,
  output logic                  core_credit
);
  import cache_pkg::*;

  ctl_state_t state_q;
  ctl_state_t state_d;
  logic       rsp_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= idle;
      rsp_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      rsp_q   <= (state_q == lookup) && status.hit;  // The answer goes out next cycle.
    end
  end

  ////////////////////////////////////////////////////////////
  // Next state and datapath commands
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    cmd           = '0;
    mem_req_valid = 1'b0;
    mem_write     = 1'b0;

    unique case (state_q)
      idle: begin
        if (core_req_valid) begin
          cmd.capture = 1'b1;
          state_d     = lookup;
        end
      end

      lookup: begin
        if (status.hit) begin
          cmd.nmru_update = 1'b1;
          cmd.write_hit   = write;
          state_d         = respond;
        end else if (status.victim_dirty) begin
          state_d = writeback;
        end else begin
          state_d = refill;
        end
      end

      // The victim line goes out under its own tag.
      writeback: begin
        mem_req_valid       = 1'b1;
        mem_write           = 1'b1;
        cmd.victim_addr_sel = 1'b1;
        if (mem_done) state_d = refill;
      end

      refill: begin
        mem_req_valid = 1'b1;
        if (mem_done) begin
          cmd.allocate = 1'b1;  // Refill data is only valid in the done cycle.
          state_d      = lookup;
        end
      end

      respond: begin
        state_d = idle;
      end

      default: begin
        state_d = idle;
      end
    endcase
  end

  // Each response hands the single credit back to the core.
  assign core_rsp_valid = rsp_q;
  assign core_credit    = rsp_q;

endmodule

/* src/l1_cache.sv */
`timescale 1ns/1ps

module l1_cache (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 core_req_valid,
  input  cache_pkg::core_req_t core_req,
  output logic                 core_rsp_valid,
  output cache_pkg::core_rsp_t core_rsp,
  output logic                 core_credit,
  output logic                 mem_req_valid,
  output cache_pkg::mem_req_t  mem_req,
  input  logic                 mem_done,
  input  cache_pkg::line_t     mem_rdata
);
  import cache_pkg::*;

  ctl_cmd_t   cmd;
  dp_status_t status;
  index_t     index;
  way_vec_t   hit_vec;
  way_vec_t   victim_vec;
  word_t      rsp_data;
  word_t      mem_addr;
  line_t      mem_wdata;
  logic       mem_write;

  cache_control u_control (
    .clk,
    .rst_n,
    .core_req_valid,
    .write          (status.req_write),
    .status,
    .mem_done,
    .cmd,
    .mem_req_valid,
    .mem_write,
    .core_rsp_valid,
    .core_credit
  );

  cache_datapath u_datapath (
    .clk, .rst_n, .core_req, .cmd, .mem_rdata, .victim_vec,
    .status, .index, .hit_vec, .rsp_data, .mem_addr, .mem_wdata
  );

  nmru_policy u_nmru (
    .clk, .rst_n, .index, .update(cmd.nmru_update), .hit_vec, .victim_vec
  );

  assign core_rsp.rdata = rsp_data;
  assign mem_req.write  = mem_write;
  assign mem_req.addr   = mem_addr;
  assign mem_req.wdata  = mem_wdata;

endmodule

/* tests/l1_cache_sva.sv */
`timescale 1ns/1ps

module l1_cache_sva (
  input logic                clk,
  input logic                rst_n,
  input logic                core_req_valid,
  input logic                core_rsp_valid,
  input logic                core_credit,
  input logic                mem_req_valid,
  input cache_pkg::mem_req_t mem_req,
  input logic                mem_done
);
  import cache_pkg::*;

  int   violations = 0;
  int   credits;
  logic started;

  // Mirror of the credits the core holds.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits <= core_credits;
      started <= 1'b0;
    end else begin
      credits <= credits - int'(core_req_valid) + int'(core_credit);
      started <= started | core_req_valid;
    end
  end

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
      !started |-> !core_rsp_valid && !core_credit && !mem_req_valid)
    else begin
      $error("Cache output active before the first request");
      violations++;
    end

  a_credit_held: assert property (@(posedge clk) disable iff (!rst_n)
      core_req_valid |-> credits > 0)
    else begin
      $error("Request issued without a credit");
      violations++;
    end

  a_rsp_with_credit: assert property (@(posedge clk) disable iff (!rst_n)
      core_rsp_valid == core_credit)
    else begin
      $error("Response and credit pulse are not paired");
      violations++;
    end

  a_rsp_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
      core_rsp_valid |-> credits < core_credits)
    else begin
      $error("Response without an outstanding request");
      violations++;
    end

  // The memory request holds until the done pulse.
  a_mem_stable: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req_valid && !mem_done |=> mem_req_valid && $stable(mem_req))
    else begin
      $error("Memory request changed before done");
      violations++;
    end

endmodule

bind l1_cache l1_cache_sva u_sva (.*);

/* tests/l1_cache_tb.sv */
`timescale 1ns/1ps

module l1_cache_tb;
  import cache_pkg::*;

  localparam int num_random   = 200;
  localparam int num_directed = 15;
  localparam int max_latency  = 6;
  localparam int cycle_limit  = (num_directed + num_random) * (2 * max_latency + 4 + 4) + 500;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      core_req_valid;
  core_req_t core_req;
  logic      core_rsp_valid;
  core_rsp_t core_rsp;
  logic      core_credit;
  logic      mem_req_valid;
  mem_req_t  mem_req;
  logic      mem_done;
  line_t     mem_rdata;

  int    seed       = 66271;
  int    errors     = 0;
  int    credits    = core_credits;
  int    cycles     = 0;
  int    rsp_age    = 0;
  logic  mem_seen   = 1'b0;
  logic  expect_hit = 1'b0;
  word_t cur_addr;
  word_t expected_word;
  word_t shadow [word_t];
  line_t mem_lines [word_t];
  int    mem_reads  = 0;
  int    mem_writes = 0;
  logic  mem_busy   = 1'b0;
  int    mem_wait   = 0;

  l1_cache DUT (.*);

  always #10 clk = ~clk;

  function automatic word_t fill_word(word_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
  endfunction

  function automatic line_t fill_line(word_t line_addr);
    line_t line;
    for (int w = 0; w < words_per_line; w++) begin
      line[w*word_bits +: word_bits] = fill_word(line_addr + word_t'(4 * w));
    end
    return line;
  endfunction

  function automatic word_t make_addr(tag_t tag, index_t idx, int w);
    return {tag, idx, 2'(w), 2'b00};
  endfunction

  ////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    line_t rdata;
    rdata = mem_rdata;
    if (mem_done) begin
      mem_busy = 1'b0;  // The cache takes the done at this edge.
      #1;
      mem_done = 1'b0;
    end else if (rst_n && mem_req_valid) begin
      if (!mem_busy) begin
        mem_busy = 1'b1;
        mem_wait = int'($unsigned($random(seed)) % max_latency);
      end
      if (mem_wait == 0) begin
        if (mem_req.write) begin
          mem_lines[mem_req.addr] = mem_req.wdata;
          mem_writes++;
        end else begin
          rdata = mem_lines.exists(mem_req.addr) ? mem_lines[mem_req.addr]
                                                 : fill_line(mem_req.addr);
          mem_reads++;
        end
        #1;
        mem_rdata = rdata;
        mem_done  = 1'b1;
      end else begin
        mem_wait--;
      end
    end
  end

  // Request age and memory activity are counted where outputs are stable.
  always @(negedge clk) begin
    cycles++;
    if (core_req_valid) begin
      rsp_age  = 0;
      mem_seen = 1'b0;
    end else begin
      rsp_age++;
    end
    if (mem_req_valid) mem_seen = 1'b1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the cache stopped answering after %0d cycles.", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
      core_rsp_valid |-> core_rsp.rdata == expected_word)
    else begin
      errors++;
      $display("Fail at %0t: addr %h returned %h, expected %h",
               $time, cur_addr, $sampled(core_rsp.rdata), expected_word);
    end

  a_hit_timing: assert property (@(posedge clk) disable iff (!rst_n)
      core_rsp_valid && expect_hit |-> rsp_age == 2 && !mem_seen)
    else begin
      errors++;
      $display("Fail at %0t: addr %h was not answered as a hit", $time, cur_addr);
    end

  task automatic issue(input logic write, input word_t addr, input word_t wdata, input logic hit);
    @(posedge clk);
    #1;
    core_req_valid = 1'b1;
    core_req.write = write;
    core_req.addr  = addr;
    core_req.wdata = wdata;
    cur_addr       = addr;
    expect_hit     = hit;
    if (write) begin
      shadow[addr]  = wdata;
      expected_word = wdata;
    end else begin
      expected_word = shadow.exists(addr) ? shadow[addr] : fill_word(addr);
    end
    credits--;
    @(posedge clk);
    #1;
    core_req_valid = 1'b0;
    while (credits < core_credits) begin
      @(negedge clk);
      if (core_credit) credits++;
    end
  endtask

  initial begin
    logic   wr;
    int     pick;
    index_t idx;
    tag_t   tag;
    rst_n          = 1'b0;
    core_req_valid = 1'b0;
    core_req       = '0;
    mem_done       = 1'b0;
    mem_rdata      = '0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (3) @(posedge clk);

    issue(1'b0, make_addr(24'h000100, 4'd1, 0), '0, 1'b0);  // Cold reads.
    issue(1'b0, make_addr(24'h000100, 4'd1, 3), '0, 1'b1);
    issue(1'b0, make_addr(24'h00abcd, 4'd7, 2), '0, 1'b0);

    issue(1'b1, make_addr(24'h000200, 4'd2, 1), 32'hcafe_0001, 1'b0);
    issue(1'b0, make_addr(24'h000200, 4'd2, 1), '0, 1'b1);
    issue(1'b0, make_addr(24'h000200, 4'd2, 1), '0, 1'b1);

    // Three tags in set 3 push the first dirty line out to memory.
    for (int t = 1; t <= 3; t++) begin
      issue(1'b1, make_addr(tag_t'(t * 16), 4'd3, 2), 32'hd00d_0000 + word_t'(t), 1'b0);
    end
    issue(1'b0, make_addr(24'h000010, 4'd3, 2), '0, 1'b0);

    issue(1'b0, make_addr(24'h000040, 4'd5, 0), '0, 1'b0);
    issue(1'b0, make_addr(24'h000050, 4'd5, 0), '0, 1'b0);
    issue(1'b0, make_addr(24'h000040, 4'd5, 1), '0, 1'b1);
    issue(1'b0, make_addr(24'h000060, 4'd5, 0), '0, 1'b0);
    issue(1'b0, make_addr(24'h000040, 4'd5, 2), '0, 1'b1);  // B was evicted, not A.

    for (int n = 0; n < num_random; n++) begin
      wr   = ($random(seed) & 1) != 0;
      pick = int'($unsigned($random(seed)) % 3);
      idx  = index_t'(6 + 4 * pick);
      tag  = tag_t'(24'h000300 + $unsigned($random(seed)) % 8);
      issue(wr, make_addr(tag, idx, int'($unsigned($random(seed)) % 4)),
            word_t'($random(seed)), 1'b0);
    end

    repeat (4) @(posedge clk);
    $display("Finished: %0d data errors, %0d protocol errors, %0d memory reads, %0d memory writes",
             errors, DUT.u_sva.violations, mem_reads, mem_writes);
    if (errors == 0 && DUT.u_sva.violations == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
src/cache_pkg.sv
src/line_array.sv
src/nmru_policy.sv
src/cache_datapath.sv
src/cache_control.sv
src/l1_cache.sv
tests/l1_cache_sva.sv
tests/l1_cache_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module l1_cache_tb -f vlog.f -o l1_cache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/l1_cache_sim +verilator+error+limit+1000 > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "All checks passed" "$log"; then
  exit 0
fi
echo "Pass message not found in $log"
exit 1
